// ==== verilog.f ====
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
sim/controlUnit_props.sv
sim/controlUnitTb.sv

// ==== sim/controlUnitTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;

    import isaPkg::*;
    import ctrlPkg::*;

    typedef enum logic [1:0] {
        okDone,
        ovTrap,
        opTrap
    } outcome_t;

    typedef struct packed {
        opcode_t  opcode;
        funct_t   funct;
        logic     overflow;
        outcome_t outcome;
        aluOp_t   aluOp;
        regDst_t  regDst;
        aluSrcB_t aluSrcB;
        cause_t   cause;
    } stimRow_t;

    logic         clk = 1'b0;
    logic         reset;
    opcode_t      opcode;
    funct_t       funct;
    logic         overflow;
    controlWord_t ctrl;
    logic         resetOut;

    stimRow_t rows[$];
    int       valueErrors = 0;
    int       sequenceErrors = 0;
    int       assertErrors;
    int       cycleCount = 0;
    int       cycleLimit;
    int       fetchCycles;

    controlUnit dut_i (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    always #50 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: no instruction fetch seen within %0d cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        valueErrors++;
    endtask

    task automatic checkAluOp(input string name, input aluOp_t got, input aluOp_t exp);
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic checkRegDst(input string name, input regDst_t got, input regDst_t exp);
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic checkSrcB(input string name, input aluSrcB_t got, input aluSrcB_t exp);
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic checkWbSel(input string name, input wbSel_t got, input wbSel_t exp);
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic checkCause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic checkCycles(input string name, input int got, input int exp);
        if (got != exp) begin
            reportMismatch(name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            reportMismatch(name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    function automatic logic [6:0] writeEnables(controlWord_t c);
        return {c.irWrite, c.pcWrite, c.epcWrite, c.regWrite, c.writeA, c.writeB, c.aluOutWrite};
    endfunction

    // Cycles from one IR load to the next
    function automatic int expectedSpacing(outcome_t outcome);
        case (outcome)
            ovTrap: return FETCH_CYCLES + DECODE_CYCLES + 2 + TRAP_CYCLES;
            opTrap: return FETCH_CYCLES + DECODE_CYCLES + TRAP_CYCLES;
            default: return FETCH_CYCLES + DECODE_CYCLES + EXEC_CYCLES;
        endcase
    endfunction

    task automatic addRow(input opcode_t op, input funct_t fn, input logic ovf,
                          input outcome_t outcome, input aluOp_t aluOp, input regDst_t dst,
                          input aluSrcB_t srcB, input cause_t cause);
        stimRow_t row;
        row.opcode   = op;
        row.funct    = fn;
        row.overflow = ovf;
        row.outcome  = outcome;
        row.aluOp    = aluOp;
        row.regDst   = dst;
        row.aluSrcB  = srcB;
        row.cause    = cause;
        rows.push_back(row);
    endtask

    task automatic loadTable();
        addRow(OP_RTYPE, FN_ADD, 1'b0, okDone, ALU_ADD, DST_RD, SRCB_REGB, 2'd0);
        addRow(OP_RTYPE, FN_SUB, 1'b0, okDone, ALU_SUB, DST_RD, SRCB_REGB, 2'd0);
        addRow(OP_RTYPE, FN_AND, 1'b0, okDone, ALU_AND, DST_RD, SRCB_REGB, 2'd0);
        addRow(OP_ADDI, 6'd0, 1'b0, okDone, ALU_ADD, DST_RT, SRCB_IMM, 2'd0);
        addRow(OP_ADDIU, 6'd0, 1'b0, okDone, ALU_ADD, DST_RT, SRCB_IMM, 2'd0);
        // Load word opcode is not supported
        addRow(6'h23, 6'd0, 1'b0, opTrap, 3'd0, 2'd0, 3'd0, CAUSE_OPCODE);
        addRow(OP_RTYPE, FN_ADD, 1'b1, ovTrap, ALU_ADD, DST_RD, SRCB_REGB, CAUSE_OVERFLOW);
        addRow(OP_RTYPE, FN_SUB, 1'b1, ovTrap, ALU_SUB, DST_RD, SRCB_REGB, CAUSE_OVERFLOW);
        // ADDU function with overflow high still traps on opcode
        addRow(OP_RTYPE, 6'h21, 1'b1, opTrap, 3'd0, 2'd0, 3'd0, CAUSE_OPCODE);
        addRow(OP_RTYPE, FN_AND, 1'b1, okDone, ALU_AND, DST_RD, SRCB_REGB, 2'd0);
        addRow(OP_ADDI, 6'd0, 1'b1, ovTrap, ALU_ADD, DST_RT, SRCB_IMM, CAUSE_OVERFLOW);
        addRow(OP_ADDIU, 6'd0, 1'b1, okDone, ALU_ADD, DST_RT, SRCB_IMM, 2'd0);
    endtask

    // Starts at the IR load edge and ends at the next IR load
    task automatic runRow(input int index);
        stimRow_t row;
        string    tag;
        int       cycles = 0;
        int       execWrites = 0;
        int       regWrites = 0;
        int       epcWrites = 0;
        int       vectorWrites = 0;
        int       epcCycle = 0;
        int       vectorCycle = 0;
        aluOp_t   gotAluOp;
        aluSrcB_t gotSrcB;
        regDst_t  gotRegDst;
        wbSel_t   gotWbSel;
        cause_t   gotCause;
        row = rows[index];
        tag = $sformatf("row %0d", index);
        @(posedge clk);
        opcode   <= row.opcode;
        funct    <= row.funct;
        overflow <= row.overflow;
        do begin
            @(negedge clk);
            cycles++;
            // Execute uses register A, decode uses the PC
            if (ctrl.aluOutWrite && ctrl.aluSrcA == SRCA_REGA) begin
                execWrites++;
                gotAluOp = ctrl.aluOp;
                gotSrcB  = ctrl.aluSrcB;
            end
            if (ctrl.regWrite) begin
                regWrites++;
                gotRegDst = ctrl.regDst;
                gotWbSel  = ctrl.memToReg;
            end
            if (ctrl.epcWrite) begin
                epcWrites++;
                epcCycle = cycles;
                gotCause = ctrl.causeCtrl;
            end
            if (ctrl.pcWrite && ctrl.pcSource == PCS_VECTOR) begin
                vectorWrites++;
                vectorCycle = cycles;
            end
        end while (!ctrl.irWrite);

        checkCycles({tag, " irWrite spacing"}, cycles, expectedSpacing(row.outcome));
        if (row.outcome == opTrap) begin
            checkCount({tag, " execute aluOutWrite pulses"}, execWrites, 0);
        end else begin
            checkCount({tag, " execute aluOutWrite pulses"}, execWrites, 1);
            checkAluOp({tag, " aluOp"}, gotAluOp, row.aluOp);
            checkSrcB({tag, " aluSrcB"}, gotSrcB, row.aluSrcB);
        end
        if (row.outcome == okDone) begin
            checkCount({tag, " regWrite pulses"}, regWrites, 1);
            checkRegDst({tag, " regDst"}, gotRegDst, row.regDst);
            checkWbSel({tag, " memToReg"}, gotWbSel, WB_ALUOUT);
            checkCount({tag, " epcWrite pulses"}, epcWrites, 0);
            checkCount({tag, " vector pcWrite pulses"}, vectorWrites, 0);
        end else begin
            checkCount({tag, " regWrite pulses"}, regWrites, 0);
            checkCount({tag, " epcWrite pulses"}, epcWrites, 1);
            checkCount({tag, " vector pcWrite pulses"}, vectorWrites, 1);
            checkCause({tag, " causeCtrl"}, gotCause, row.cause);
            if (vectorCycle != epcCycle + 1) begin
                $display("%s: vector PC write did not follow the EPC write", tag);
                sequenceErrors++;
            end
        end
    endtask

    initial begin
        reset    = 1'b1;
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        loadTable();
        cycleLimit = 12 * rows.size() + 20;

        @(posedge clk);
        @(negedge clk);
        checkFlag("resetOut in reset", resetOut, 1'b1);
        checkFlag("write enables in reset", |writeEnables(ctrl), 1'b0);
        @(posedge clk);
        reset <= 1'b0;
        // State leaves reset one edge after release
        @(negedge clk);
        checkFlag("resetOut after release", resetOut, 1'b1);
        checkFlag("write enables after release", |writeEnables(ctrl), 1'b0);
        fetchCycles = 0;
        do begin
            @(negedge clk);
            fetchCycles++;
            checkFlag("resetOut in fetch", resetOut, 1'b0);
        end while (!ctrl.irWrite);
        checkCycles("first irWrite fetch cycle", fetchCycles, FETCH_CYCLES);
        checkFlag("pcWrite with first irWrite", ctrl.pcWrite, 1'b1);

        foreach (rows[i]) begin
            runRow(i);
        end

        assertErrors = dut_i.props_i.failCount;
        $display("Value errors: %0d, sequence errors: %0d, assertion errors: %0d",
                 valueErrors, sequenceErrors, assertErrors);
        if (valueErrors + sequenceErrors + assertErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/controlUnit_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlUnitProps (
    input logic                  clk,
    input logic                  reset,
    input ctrlPkg::controlWord_t ctrl,
    input logic                  resetOut
);

    int failCount = 0;

    // IR load always comes with the PC update
    irLoadsPc: assert property (@(posedge clk) disable iff (reset) ctrl.irWrite |-> ctrl.pcWrite)
        else begin
            failCount++;
            $error("irWrite asserted without pcWrite");
        end

    noWriteDuringTrap: assert property (@(posedge clk) disable iff (reset)
                                        !(ctrl.regWrite && ctrl.epcWrite))
        else begin
            failCount++;
            $error("regWrite and epcWrite asserted together");
        end

    quietInReset: assert property (@(posedge clk) resetOut |->
        !(ctrl.irWrite || ctrl.pcWrite || ctrl.epcWrite || ctrl.regWrite ||
          ctrl.writeA || ctrl.writeB || ctrl.aluOutWrite))
        else begin
            failCount++;
            $error("write enable active while resetOut is high");
        end

endmodule

bind controlUnit controlUnitProps props_i (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .resetOut (resetOut)
);

`default_nettype wire

// ==== hdl/controlUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  isaPkg::opcode_t       opcode,
    input  isaPkg::funct_t        funct,
    input  logic                  overflow,
    output ctrlPkg::controlWord_t ctrl,
    output logic                  resetOut
);

    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_t instrClass;
    instrClass_t execClass;
    cuState_t    state;
    step_t       step;
    cause_t      trapCause;

    instrDecoder decoder_i (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state),
        .step       (step),
        .execClass  (execClass),
        .trapCause  (trapCause),
        .resetOut   (resetOut)
    );

    // Moore outputs from registered sequencer state
    controlEncoder encoder_i (
        .state     (state),
        .step      (step),
        .execClass (execClass),
        .trapCause (trapCause),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// ==== hdl/controlEncoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlEncoder (
    input  ctrlPkg::cuState_t     state,
    input  ctrlPkg::step_t        step,
    input  isaPkg::instrClass_t   execClass,
    input  ctrlPkg::cause_t       trapCause,
    output ctrlPkg::controlWord_t ctrl
);

    import isaPkg::*;
    import ctrlPkg::*;

    logic   immOperand;
    aluOp_t classAluOp;

    // I-type forms take the immediate and write rt
    assign immOperand = (execClass == iAddi) || (execClass == iAddiu);

    always_comb begin
        case (execClass)
            iSub: begin
                classAluOp = ALU_SUB;
            end
            iAnd: begin
                classAluOp = ALU_AND;
            end
            default: begin
                classAluOp = ALU_ADD;
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            stFetch: begin
                // PC + 4 computed while memory settles
                ctrl.aluSrcA  = SRCA_PC;
                ctrl.aluSrcB  = SRCB_FOUR;
                ctrl.aluOp    = ALU_ADD;
                ctrl.pcSource = PCS_ALU;
                if (step == step_t'(FETCH_CYCLES - 1)) begin
                    ctrl.irWrite = 1'b1;
                    ctrl.pcWrite = 1'b1;
                end
            end
            stDecode: begin
                ctrl.writeA      = 1'b1;
                ctrl.writeB      = 1'b1;
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcA     = SRCA_PC;
                ctrl.aluSrcB     = SRCB_REGB;
                ctrl.aluOp       = ALU_ADD;
            end
            stExec: begin
                case (step)
                    step_t'(0): begin
                        ctrl.aluOutWrite = 1'b1;
                        ctrl.aluSrcA     = SRCA_REGA;
                        ctrl.aluSrcB     = immOperand ? SRCB_IMM : SRCB_REGB;
                        ctrl.aluOp       = classAluOp;
                    end
                    step_t'(2): begin
                        ctrl.regWrite = 1'b1;
                        ctrl.memToReg = WB_ALUOUT;
                        ctrl.regDst   = immOperand ? DST_RT : DST_RD;
                    end
                    default: begin
                        // Idle while overflow is sampled
                        ctrl = '0;
                    end
                endcase
            end
            stTrap: begin
                if (step == step_t'(0)) begin
                    ctrl.epcWrite  = 1'b1;
                    ctrl.causeCtrl = trapCause;
                end else begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = PCS_VECTOR;
                end
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/controlSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlSequencer (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::instrClass_t instrClass,
    input  logic                overflow,
    output ctrlPkg::cuState_t   state,
    output ctrlPkg::step_t      step,
    output isaPkg::instrClass_t execClass,
    output ctrlPkg::cause_t     trapCause,
    output logic                resetOut
);

    import isaPkg::*;
    import ctrlPkg::*;

    cuState_t nextState;
    step_t    lastStep;
    logic     phaseDone;
    logic     overflowTrap;
    logic     decodeDone;

    // Final step of the running phase
    always_comb begin
        case (state)
            stFetch:  lastStep = step_t'(FETCH_CYCLES - 1);
            stDecode: lastStep = step_t'(DECODE_CYCLES - 1);
            stExec:   lastStep = step_t'(EXEC_CYCLES - 1);
            stTrap:   lastStep = step_t'(TRAP_CYCLES - 1);
            default:  lastStep = '0;
        endcase
    end

    assign phaseDone  = (step == lastStep);
    assign decodeDone = (state == stDecode) && phaseDone;

    // ALU result is checked one cycle after the execute operation
    assign overflowTrap = (state == stExec) && (step == step_t'(1)) && overflow &&
                          (execClass inside {iAdd, iSub, iAddi});

    always_comb begin
        nextState = state;
        case (state)
            stReset: begin
                nextState = stFetch;
            end
            stFetch: begin
                if (phaseDone) begin
                    nextState = stDecode;
                end
            end
            stDecode: begin
                if (phaseDone) begin
                    nextState = (instrClass == iIllegal) ? stTrap : stExec;
                end
            end
            stExec: begin
                if (overflowTrap) begin
                    nextState = stTrap;
                end else if (phaseDone) begin
                    nextState = stFetch;
                end
            end
            stTrap: begin
                if (phaseDone) begin
                    nextState = stFetch;
                end
            end
            default: begin
                nextState = stReset;
            end
        endcase
    end

    // Every phase change restarts the step count
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stReset;
            step  <= '0;
        end else begin
            state <= nextState;
            if (nextState != state) begin
                step <= '0;
            end else begin
                step <= step + step_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decodeDone) begin
            execClass <= instrClass;
            trapCause <= CAUSE_OPCODE;
        end else if (overflowTrap) begin
            trapCause <= CAUSE_OVERFLOW;
        end
    end

    assign resetOut = (state == stReset);

endmodule

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
    input  isaPkg::opcode_t     opcode,
    input  isaPkg::funct_t      funct,
    output isaPkg::instrClass_t instrClass
);

    import isaPkg::*;

    always_comb begin
        instrClass = iIllegal;
        case (opcode)
            OP_RTYPE: begin
                // Only three R-type functions survive
                case (funct)
                    FN_ADD: begin
                        instrClass = iAdd;
                    end
                    FN_SUB: begin
                        instrClass = iSub;
                    end
                    FN_AND: begin
                        instrClass = iAnd;
                    end
                    default: begin
                        instrClass = iIllegal;
                    end
                endcase
            end
            OP_ADDI: begin
                instrClass = iAddi;
            end
            OP_ADDIU: begin
                instrClass = iAddiu;
            end
            default: begin
                instrClass = iIllegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] aluSrcA_t;
    typedef logic [2:0] aluSrcB_t;
    typedef logic [1:0] regDst_t;
    typedef logic [2:0] wbSel_t;
    typedef logic [2:0] pcSrc_t;
    typedef logic [1:0] cause_t;

    // Zero leaves the ALU idle
    localparam aluOp_t ALU_ADD = 3'd1;
    localparam aluOp_t ALU_SUB = 3'd2;
    localparam aluOp_t ALU_AND = 3'd3;

    localparam aluSrcA_t SRCA_PC   = 2'd0;
    localparam aluSrcA_t SRCA_REGA = 2'd2;

    localparam aluSrcB_t SRCB_REGB = 3'd0;
    localparam aluSrcB_t SRCB_FOUR = 3'd1;
    localparam aluSrcB_t SRCB_IMM  = 3'd2;

    localparam regDst_t DST_RT = 2'd0;
    localparam regDst_t DST_RD = 2'd1;

    localparam wbSel_t WB_ALUOUT = 3'd3;

    localparam pcSrc_t PCS_ALU    = 3'd2;
    localparam pcSrc_t PCS_VECTOR = 3'd3;

    localparam cause_t CAUSE_OPCODE   = 2'd0;
    localparam cause_t CAUSE_OVERFLOW = 2'd1;

    // Everything the datapath sees in one cycle
    typedef struct packed {
        logic     irWrite;
        logic     pcWrite;
        logic     epcWrite;
        logic     regWrite;
        logic     writeA;
        logic     writeB;
        logic     aluOutWrite;
        cause_t   causeCtrl;
        regDst_t  regDst;
        wbSel_t   memToReg;
        aluSrcA_t aluSrcA;
        aluSrcB_t aluSrcB;
        aluOp_t   aluOp;
        pcSrc_t   pcSource;
    } controlWord_t;

    typedef enum logic [2:0] {
        stReset,
        stFetch,
        stDecode,
        stExec,
        stTrap
    } cuState_t;

    typedef logic [2:0] step_t;

    // Phase lengths in clock cycles
    localparam int FETCH_CYCLES  = 4;
    localparam int DECODE_CYCLES = 2;
    localparam int EXEC_CYCLES   = 3;
    localparam int TRAP_CYCLES   = 2;

endpackage

`default_nettype wire

// ==== hdl/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // Instruction word fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    localparam opcode_t OP_RTYPE = 6'd0;
    localparam opcode_t OP_ADDI  = 6'd8;
    localparam opcode_t OP_ADDIU = 6'd9;

    // R-type function codes
    localparam funct_t FN_ADD = 6'd32;
    localparam funct_t FN_SUB = 6'd34;
    localparam funct_t FN_AND = 6'd36;

    // One decoded class per supported operation
    typedef enum logic [2:0] {
        iAdd,
        iSub,
        iAnd,
        iAddi,
        iAddiu,
        iIllegal
    } instrClass_t;

endpackage

`default_nettype wire
